/* sim.f */
src/cr_pkg.sv
src/cr_mul_bank.sv
src/cr_mac_bank.sv
src/cr_debug_bank.sv
src/cr_read_return.sv
src/accel_cr_mem.sv
testbench/tb_clock_gen.sv
testbench/tb_accel_cr_mem.sv

/* run_sim.sh */
#!/bin/sh
# build and run the control-register testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f sim.f \
    --top-module tb_accel_cr_mem \
    -Mdir obj_dir \
    -o sim_tb

# the log decides pass or fail, so a failing run must not stop the script here
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^Everything OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* testbench/tb_accel_cr_mem.sv */
//--------------------
// tb_accel_cr_mem
// drives the core bus and farm of the control-register
// block, keeps shadow registers and checks the DUT ports
// against them with concurrent assertions
//--------------------
`timescale 1ns/1ns
`default_nettype none

module tb_accel_cr_mem;
    import cr_pkg::*;

    localparam int MUL_NUM        = 8;
    localparam int MAC_NUM        = 2;
    localparam int MUL_PER_MAC    = MUL_NUM / MAC_NUM;
    localparam int TIMEOUT_CYCLES = 2000;

    logic                                   clk;
    logic                                   rst;
    cr_bus_t                                bus;
    cr_word_t                               q;
    mul_out_t [MUL_NUM-1:0]                 mul_out;
    mac_out_t [MAC_NUM-1:0]                 mac_out;
    mul_in_t  [MUL_NUM-1:0]                 mul_in;
    int8_t    [MAC_NUM-1:0]                 mac_bias;
    prod_t    [MAC_NUM-1:0][MUL_PER_MAC-1:0] mac_mul_result;

    // shadow registers
    cr_word_t                                exp_q;
    mul_in_t  [MUL_NUM-1:0]                  exp_mul_in;
    mul_out_t [MUL_NUM-1:0]                  exp_mul_samp;
    int8_t    [MAC_NUM-1:0]                  exp_bias;
    mac_out_t [MAC_NUM-1:0]                  exp_mac_samp;
    cr_word_t [DEBUG_NUM-1:0]                exp_dbg;
    prod_t    [MAC_NUM-1:0][MUL_PER_MAC-1:0] exp_mmr;

    logic [15:0] lfsr_state = 16'd15903;
    int          cycle_count = 0;

    tb_clock_gen #(.PERIOD_NS(40)) u_clock (.clk(clk));

    accel_cr_mem UUT (
        .clk            (clk),
        .rst            (rst),
        .bus            (bus),
        .q              (q),
        .mul_out        (mul_out),
        .mac_out        (mac_out),
        .mul_in         (mul_in),
        .mac_bias       (mac_bias),
        .mac_mul_result (mac_mul_result)
    );

    //--------------------
    // helpers
    //--------------------
    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one LFSR step per bit taken
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // region [11:8], index [7:3], select [2:0]
    function automatic cr_addr_t make_addr(logic [3:0] region, int idx, logic [2:0] sel);
        logic [4:0] i5;
        i5 = idx[4:0];
        return {20'b0, region, i5, sel};
    endfunction

    task automatic abort_run();
        $display("Something failed");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic bus_write(cr_addr_t addr, cr_word_t data);
        @(negedge clk);
        bus.wren    = 1'b1;
        bus.rden    = 1'b0;
        bus.address = addr;
        bus.data    = data;
    endtask

    task automatic bus_read(cr_addr_t addr);
        @(negedge clk);
        bus.wren    = 1'b0;
        bus.rden    = 1'b1;
        bus.address = addr;
        bus.data    = '0;
    endtask

    // address on the bus, no strobe
    task automatic bus_quiet(cr_addr_t addr);
        @(negedge clk);
        bus.wren    = 1'b0;
        bus.rden    = 1'b0;
        bus.address = addr;
    endtask

    task automatic idle_cycles(int n);
        repeat (n) begin
            @(negedge clk);
            bus.wren = 1'b0;
            bus.rden = 1'b0;
        end
    endtask

    // new farm outputs, held until the next call
    task automatic drive_farm();
        logic [31:0] r;
        for (int i = 0; i < MUL_NUM; i++) begin
            r = rand_bits(17);
            mul_out[i] = r[16:0];
        end
        for (int k = 0; k < MAC_NUM; k++) begin
            r = rand_bits(8);
            mac_out[k] = r[7:0];
        end
    endtask

    //--------------------
    // reference model
    //--------------------
    always @(posedge clk) begin : model_update
        logic       addr_ok;
        logic [3:0] region;
        logic [2:0] sel;
        int         i;
        logic       hit;
        cr_word_t   word;
        addr_ok = (bus.address[31:12] == 20'b0);
        region  = bus.address[11:8];
        i       = int'(bus.address[7:3]);
        sel     = bus.address[2:0];
        hit     = 1'b0;
        word    = '0;
        if (rst) begin
            exp_q        <= '0;
            exp_mul_in   <= '0;
            exp_mul_samp <= '0;
            exp_bias     <= '0;
            exp_mac_samp <= '0;
            exp_dbg      <= '0;
        end else begin
            exp_mul_samp <= mul_out;
            exp_mac_samp <= mac_out;
            if (bus.wren && addr_ok) begin
                if (region == REGION_MUL && i < MUL_NUM) begin
                    if (sel == SEL_MUL_MULTIPLICAND) begin
                        exp_mul_in[i].multiplicand <= bus.data[7:0];
                    end else if (sel == SEL_MUL_MULTIPLIER) begin
                        exp_mul_in[i].multiplier <= bus.data[7:0];
                    end
                end
                if (region == REGION_MAC && sel == SEL_MAC_BIAS && i < MAC_NUM) begin
                    exp_bias[i] <= bus.data[7:0];
                end
                if (region == REGION_DEBUG && sel == SEL_DEBUG && i < DEBUG_NUM) begin
                    exp_dbg[i] <= bus.data;
                end
            end
            if (bus.rden && addr_ok) begin
                if (region == REGION_MUL && i < MUL_NUM && sel == SEL_MUL_RESULT) begin
                    hit  = 1'b1;
                    word = {16'b0, exp_mul_samp[i].result};
                end
                if (region == REGION_MUL && i < MUL_NUM && sel == SEL_MUL_DONE) begin
                    hit  = 1'b1;
                    word = {31'b0, exp_mul_samp[i].done};
                end
                if (region == REGION_MAC && i < MAC_NUM && sel == SEL_MAC_RESULT) begin
                    hit  = 1'b1;
                    word = {24'b0, exp_mac_samp[i].int8_result};
                end
                if (region == REGION_DEBUG && i < DEBUG_NUM && sel == SEL_DEBUG) begin
                    hit  = 1'b1;
                    word = exp_dbg[i];
                end
            end
            // no claim, q holds
            if (hit) begin
                exp_q <= word;
            end
        end
    end

    // MAC k sees products k*MUL_PER_MAC onward
    always_comb begin
        for (int k = 0; k < MAC_NUM; k++) begin
            for (int j = 0; j < MUL_PER_MAC; j++) begin
                exp_mmr[k][j] = exp_mul_samp[k * MUL_PER_MAC + j].result;
            end
        end
    end

    //--------------------
    // checks
    //--------------------
    a_reset_q: assert property (@(posedge clk) $fell(rst) |-> (q == '0))
        else begin
            $display("ERR %0t q dut=%h exp=%h", $time, $sampled(q), 32'h0);
            abort_run();
        end

    a_q: assert property (@(posedge clk) disable iff (rst) q == exp_q)
        else begin
            $display("ERR %0t q dut=%h exp=%h", $time, $sampled(q), $sampled(exp_q));
            abort_run();
        end

    a_mul_in: assert property (@(posedge clk) disable iff (rst) mul_in == exp_mul_in)
        else begin
            $display("ERR %0t mul_in dut=%h exp=%h", $time, $sampled(mul_in),
                     $sampled(exp_mul_in));
            abort_run();
        end

    a_mac_bias: assert property (@(posedge clk) disable iff (rst) mac_bias == exp_bias)
        else begin
            $display("ERR %0t mac_bias dut=%h exp=%h", $time, $sampled(mac_bias),
                     $sampled(exp_bias));
            abort_run();
        end

    a_mac_mul_result: assert property (@(posedge clk) disable iff (rst)
                                       mac_mul_result == exp_mmr)
        else begin
            $display("ERR %0t mac_mul_result dut=%h exp=%h", $time,
                     $sampled(mac_mul_result), $sampled(exp_mmr));
            abort_run();
        end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    //--------------------
    // stimulus
    //--------------------
    initial begin : stimulus
        logic [31:0] r;
        logic [3:0]  region;
        logic [2:0]  sel;
        int          idx;
        rst     = 1'b1;
        bus     = '0;
        mul_out = '0;
        mac_out = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        idle_cycles(2);

        // operand writes, read-only selects and out-of-range indexes
        for (int i = 0; i < MUL_NUM; i++) begin
            bus_write(make_addr(REGION_MUL, i, SEL_MUL_MULTIPLICAND), rand_bits(32));
            bus_write(make_addr(REGION_MUL, i, SEL_MUL_MULTIPLIER), rand_bits(32));
            bus_write(make_addr(REGION_MUL, i, SEL_MUL_RESULT), rand_bits(32));
            bus_write(make_addr(REGION_MUL, i, SEL_MUL_DONE), rand_bits(32));
            bus_write(make_addr(REGION_MUL, i, 3'd5), rand_bits(32));
        end
        for (int i = MUL_NUM; i < MUL_NUM + 4; i++) begin
            bus_write(make_addr(REGION_MUL, i, SEL_MUL_MULTIPLICAND), rand_bits(32));
            bus_write(make_addr(REGION_MUL, i, SEL_MUL_MULTIPLIER), rand_bits(32));
        end

        // multiplier results and done flags
        repeat (4) begin
            drive_farm();
            idle_cycles(2);
            for (int i = 0; i < MUL_NUM; i++) begin
                bus_read(make_addr(REGION_MUL, i, SEL_MUL_RESULT));
                bus_read(make_addr(REGION_MUL, i, SEL_MUL_DONE));
            end
            idle_cycles(1);
        end

        // biases and MAC results
        repeat (3) begin
            for (int k = 0; k <= MAC_NUM; k++) begin
                bus_write(make_addr(REGION_MAC, k, SEL_MAC_BIAS), rand_bits(32));
            end
            drive_farm();
            idle_cycles(2);
            for (int k = 0; k <= MAC_NUM; k++) begin
                bus_read(make_addr(REGION_MAC, k, SEL_MAC_RESULT));
                bus_read(make_addr(REGION_MAC, k, SEL_MAC_BIAS));
            end
        end

        // debug scratch, one past the end too
        for (int d = 0; d <= DEBUG_NUM; d++) begin
            bus_write(make_addr(REGION_DEBUG, d, SEL_DEBUG), rand_bits(32));
        end
        for (int d = 0; d <= DEBUG_NUM; d++) begin
            bus_read(make_addr(REGION_DEBUG, d, SEL_DEBUG));
        end

        // reads that must leave q alone
        bus_read(make_addr(REGION_DEBUG, 1, SEL_DEBUG));
        bus_read(make_addr(4'd0, 0, 3'd0));
        bus_read(make_addr(4'd4, 1, 3'd1));
        bus_read(make_addr(4'd15, 2, 3'd2));
        bus_read(make_addr(REGION_DEBUG, 0, 3'd1));
        bus_quiet(make_addr(REGION_DEBUG, 2, SEL_DEBUG));
        bus_quiet(make_addr(REGION_MUL, 0, SEL_MUL_RESULT));
        for (int b = 12; b < 32; b += 4) begin
            bus_read(make_addr(REGION_DEBUG, 2, SEL_DEBUG) | (32'h1 << b));
            bus_write(make_addr(REGION_DEBUG, 3, SEL_DEBUG) | (32'h1 << b), rand_bits(32));
        end
        bus_read(make_addr(REGION_DEBUG, 3, SEL_DEBUG));

        // random mix over all regions
        repeat (90) begin
            r      = rand_bits(2);
            region = 4'(rand_bits(2));
            idx    = int'(rand_bits(3));
            sel    = 3'(rand_bits(3));
            if (r == 32'd0) begin
                bus_write(make_addr(region, idx, sel), rand_bits(32));
            end else if (r == 32'd3) begin
                drive_farm();
                idle_cycles(1);
            end else begin
                bus_read(make_addr(region, idx, sel));
            end
        end

        idle_cycles(2);
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/tb_clock_gen.sv */
//--------------------
// tb_clock_gen
// free-running testbench clock
//--------------------
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

`default_nettype wire

/* src/accel_cr_mem.sv */
//--------------------
// accel_cr_mem
// control-register block between the core register
// bus and the accelerator farm
//--------------------
`timescale 1ns/1ns
`default_nettype none

module accel_cr_mem #(
    parameter int MUL_NUM = 8,
    parameter int MAC_NUM = 2
) (
    input  logic                                               clk,
    input  logic                                               rst,
    // core side
    input  var cr_pkg::cr_bus_t                                bus,
    output cr_pkg::cr_word_t                                   q,
    // farm side
    input  var cr_pkg::mul_out_t [MUL_NUM-1:0]                 mul_out,
    input  var cr_pkg::mac_out_t [MAC_NUM-1:0]                 mac_out,
    output cr_pkg::mul_in_t      [MUL_NUM-1:0]                 mul_in,
    output cr_pkg::int8_t        [MAC_NUM-1:0]                 mac_bias,
    output cr_pkg::prod_t [MAC_NUM-1:0][MUL_NUM/MAC_NUM-1:0]   mac_mul_result
);
    import cr_pkg::*;

    prod_t [MUL_NUM-1:0] mul_results;
    cr_rd_t              rd_mul;
    cr_rd_t              rd_mac;
    cr_rd_t              rd_debug;

    //--------------------
    // register banks
    //--------------------
    cr_mul_bank #(
        .MUL_NUM (MUL_NUM)
    ) u_mul_bank (
        .clk     (clk),
        .rst     (rst),
        .bus     (bus),
        .mul_out (mul_out),
        .mul_in  (mul_in),
        .results (mul_results),
        .rd      (rd_mul)
    );

    cr_mac_bank #(
        .MUL_NUM (MUL_NUM),
        .MAC_NUM (MAC_NUM)
    ) u_mac_bank (
        .clk            (clk),
        .rst            (rst),
        .bus            (bus),
        .results        (mul_results),
        .mac_out        (mac_out),
        .mac_bias       (mac_bias),
        .mac_mul_result (mac_mul_result),
        .rd             (rd_mac)
    );

    cr_debug_bank u_debug_bank (
        .clk (clk),
        .rst (rst),
        .bus (bus),
        .rd  (rd_debug)
    );

    // read data back to the core
    cr_read_return u_read_return (
        .clk      (clk),
        .rst      (rst),
        .rd_mul   (rd_mul),
        .rd_mac   (rd_mac),
        .rd_debug (rd_debug),
        .q        (q)
    );

endmodule

`default_nettype wire

/* src/cr_read_return.sv */
//--------------------
// cr_read_return
// picks the bank that claims the read and registers
// its word into q, q holds when nobody claims
//--------------------
`timescale 1ns/1ns
`default_nettype none

module cr_read_return (
    input  logic               clk,
    input  logic               rst,
    input  var cr_pkg::cr_rd_t rd_mul,
    input  var cr_pkg::cr_rd_t rd_mac,
    input  var cr_pkg::cr_rd_t rd_debug,
    output cr_pkg::cr_word_t   q
);
    import cr_pkg::*;

    logic [2:0] hits;
    cr_word_t   sel_word;

    assign hits = {rd_debug.hit, rd_mac.hit, rd_mul.hit};

    always_comb begin
        sel_word = q;
        case (hits)
            3'b001:  sel_word = rd_mul.word;
            3'b010:  sel_word = rd_mac.word;
            3'b100:  sel_word = rd_debug.word;
            default: ;
        endcase
    end

    //--------------------
    // registered read port
    //--------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else if (|hits) begin
            q <= sel_word;
        end
    end

    // regions are disjoint, so banks never claim together
    a_one_hit: assert property (@(posedge clk) disable iff (rst) $onehot0(hits));

endmodule

`default_nettype wire

/* src/cr_debug_bank.sv */
//--------------------
// cr_debug_bank
// four full-width scratch registers for debug
//--------------------
`timescale 1ns/1ns
`default_nettype none

module cr_debug_bank (
    input  logic                clk,
    input  logic                rst,
    input  var cr_pkg::cr_bus_t bus,
    output cr_pkg::cr_rd_t      rd
);
    import cr_pkg::*;

    cr_word_t [DEBUG_NUM-1:0] scratch_q;
    logic                     reg_hit;
    logic [INDEX_W-1:0]       idx;

    assign idx     = addr_index(bus.address);
    assign reg_hit = addr_in_region(bus.address, REGION_DEBUG)
                  && (addr_sel(bus.address) == SEL_DEBUG)
                  && (32'(idx) < DEBUG_NUM);

    always_ff @(posedge clk) begin
        if (rst) begin
            scratch_q <= '0;
        end else if (bus.wren && reg_hit) begin
            scratch_q[idx[1:0]] <= bus.data;
        end
    end

    // whole word read back
    always_comb begin
        rd = '0;
        if (bus.rden && reg_hit) begin
            rd.hit  = 1'b1;
            rd.word = scratch_q[idx[1:0]];
        end
    end

endmodule

`default_nettype wire

/* src/cr_mac_bank.sv */
//--------------------
// cr_mac_bank
// bias registers and result samples for the neuron MACs,
// plus grouping of multiplier products per MAC
//--------------------
`timescale 1ns/1ns
`default_nettype none

module cr_mac_bank #(
    parameter  int MUL_NUM     = 8,
    parameter  int MAC_NUM     = 2,
    localparam int MUL_PER_MAC = MUL_NUM / MAC_NUM
) (
    input  logic                                           clk,
    input  logic                                           rst,
    input  var cr_pkg::cr_bus_t                            bus,
    input  var cr_pkg::prod_t    [MUL_NUM-1:0]             results,
    input  var cr_pkg::mac_out_t [MAC_NUM-1:0]             mac_out,
    output cr_pkg::int8_t        [MAC_NUM-1:0]             mac_bias,
    output cr_pkg::prod_t [MAC_NUM-1:0][MUL_PER_MAC-1:0]   mac_mul_result,
    output cr_pkg::cr_rd_t                                 rd
);
    import cr_pkg::*;

    mac_out_t [MAC_NUM-1:0] sample_q;
    logic                   region_hit;
    logic [INDEX_W-1:0]     idx;
    logic [SEL_W-1:0]       sel;

    // products must split evenly over the MACs
    if (MUL_NUM % MAC_NUM != 0) begin : g_bad_split
        $error("MUL_NUM must be a multiple of MAC_NUM");
    end

    assign region_hit = addr_in_region(bus.address, REGION_MAC);
    assign idx        = addr_index(bus.address);
    assign sel        = addr_sel(bus.address);

    // bias writes
    always_ff @(posedge clk) begin
        if (rst) begin
            mac_bias <= '0;
        end else if (bus.wren && region_hit && (sel == SEL_MAC_BIAS)) begin
            for (int k = 0; k < MAC_NUM; k++) begin
                if (idx == INDEX_W'(k)) begin
                    mac_bias[k] <= bus.data[7:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_q <= '0;
        end else begin
            sample_q <= mac_out;
        end
    end

    // MAC k takes products k*MUL_PER_MAC onward
    always_comb begin
        for (int k = 0; k < MAC_NUM; k++) begin
            for (int j = 0; j < MUL_PER_MAC; j++) begin
                mac_mul_result[k][j] = results[k*MUL_PER_MAC + j];
            end
        end
    end

    //--------------------
    // read offer
    //--------------------
    always_comb begin
        rd = '0;
        if (bus.rden && region_hit && (sel == SEL_MAC_RESULT)) begin
            for (int k = 0; k < MAC_NUM; k++) begin
                if (idx == INDEX_W'(k)) begin
                    rd.hit  = 1'b1;
                    rd.word = {24'b0, sample_q[k].int8_result};
                end
            end
        end
    end

endmodule

`default_nettype wire

/* src/cr_mul_bank.sv */
//--------------------
// cr_mul_bank
// operand registers driven to the int8 multipliers and
// per-cycle samples of their done flag and product
//--------------------
`timescale 1ns/1ns
`default_nettype none

module cr_mul_bank #(
    parameter int MUL_NUM = 8
) (
    input  logic                              clk,
    input  logic                              rst,
    input  var cr_pkg::cr_bus_t               bus,
    input  var cr_pkg::mul_out_t [MUL_NUM-1:0] mul_out,
    output cr_pkg::mul_in_t  [MUL_NUM-1:0]    mul_in,
    output cr_pkg::prod_t    [MUL_NUM-1:0]    results,
    output cr_pkg::cr_rd_t                    rd
);
    import cr_pkg::*;

    mul_out_t [MUL_NUM-1:0] sample_q;
    logic                   region_hit;
    logic [INDEX_W-1:0]     idx;
    logic [SEL_W-1:0]       sel;

    assign region_hit = addr_in_region(bus.address, REGION_MUL);
    assign idx        = addr_index(bus.address);
    assign sel        = addr_sel(bus.address);

    //--------------------
    // operand writes
    //--------------------
    // only the low byte of data carries the int8 operand
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_in <= '0;
        end else if (bus.wren && region_hit) begin
            for (int i = 0; i < MUL_NUM; i++) begin
                if (idx == INDEX_W'(i)) begin
                    case (sel)
                        SEL_MUL_MULTIPLICAND: mul_in[i].multiplicand <= bus.data[7:0];
                        SEL_MUL_MULTIPLIER:   mul_in[i].multiplier   <= bus.data[7:0];
                        default: ;
                    endcase
                end
            end
        end
    end

    // farm outputs sampled every cycle, bus independent
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_q <= '0;
        end else begin
            sample_q <= mul_out;
        end
    end

    always_comb begin
        for (int i = 0; i < MUL_NUM; i++) begin
            results[i] = sample_q[i].result;
        end
    end

    //--------------------
    // read offer
    //--------------------
    always_comb begin
        rd = '0;
        if (bus.rden && region_hit) begin
            for (int i = 0; i < MUL_NUM; i++) begin
                if (idx == INDEX_W'(i)) begin
                    case (sel)
                        SEL_MUL_RESULT: begin
                            rd.hit  = 1'b1;
                            rd.word = {16'b0, sample_q[i].result};
                        end
                        SEL_MUL_DONE: begin
                            rd.hit  = 1'b1;
                            rd.word = {31'b0, sample_q[i].done};
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    // single-cycle bus never reads and writes together
    a_no_rd_wr: assert property (@(posedge clk) disable iff (rst) !(bus.wren && bus.rden));

endmodule

`default_nettype wire

/* src/cr_pkg.sv */
//--------------------
// cr_pkg
// shared types and address map for the accelerator
// control-register block: bus word, farm structs,
// region / index / select field positions
//--------------------
`default_nettype none

package cr_pkg;

    // bus words
    typedef logic [31:0] cr_word_t;
    typedef logic [31:0] cr_addr_t;

    //--------------------
    // address map fields
    //--------------------
    localparam int REGION_LSB = 8;
    localparam int REGION_W   = 4;
    localparam int INDEX_LSB  = 3;
    localparam int INDEX_W    = 5;
    localparam int SEL_LSB    = 0;
    localparam int SEL_W      = 3;
    // bits from here up must be zero for a hit
    localparam int HIGH_LSB   = REGION_LSB + REGION_W;

    // region codes
    localparam logic [REGION_W-1:0] REGION_MUL   = 4'd1;
    localparam logic [REGION_W-1:0] REGION_MAC   = 4'd2;
    localparam logic [REGION_W-1:0] REGION_DEBUG = 4'd3;

    // register selects inside a region
    localparam logic [SEL_W-1:0] SEL_MUL_MULTIPLICAND = 3'd0;
    localparam logic [SEL_W-1:0] SEL_MUL_MULTIPLIER   = 3'd1;
    localparam logic [SEL_W-1:0] SEL_MUL_RESULT       = 3'd2;
    localparam logic [SEL_W-1:0] SEL_MUL_DONE         = 3'd3;
    localparam logic [SEL_W-1:0] SEL_MAC_BIAS         = 3'd0;
    localparam logic [SEL_W-1:0] SEL_MAC_RESULT       = 3'd1;
    localparam logic [SEL_W-1:0] SEL_DEBUG            = 3'd0;

    localparam int DEBUG_NUM = 4;

    // farm data
    typedef logic [7:0]  int8_t;
    typedef logic [15:0] prod_t;

    // core register bus, single cycle
    typedef struct packed {
        logic     wren;
        logic     rden;
        cr_addr_t address;
        cr_word_t data;
    } cr_bus_t;

    typedef struct packed {
        int8_t multiplicand;
        int8_t multiplier;
    } mul_in_t;

    typedef struct packed {
        logic  done;
        prod_t result;
    } mul_out_t;

    typedef struct packed {
        int8_t int8_result;
    } mac_out_t;

    // one bank's offer for the current read
    typedef struct packed {
        logic     hit;
        cr_word_t word;
    } cr_rd_t;

    //--------------------
    // field decode helpers
    //--------------------
    function automatic logic addr_in_region(cr_addr_t addr, logic [REGION_W-1:0] region);
        return (addr[31:HIGH_LSB] == '0) && (addr[REGION_LSB +: REGION_W] == region);
    endfunction

    function automatic logic [INDEX_W-1:0] addr_index(cr_addr_t addr);
        return addr[INDEX_LSB +: INDEX_W];
    endfunction

    function automatic logic [SEL_W-1:0] addr_sel(cr_addr_t addr);
        return addr[SEL_LSB +: SEL_W];
    endfunction

endpackage

`default_nettype wire
